// ==== Makefile ====
TOP := dcache_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f dcache.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; \
		then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== dcache.f ====
+incdir+source
source/dcache_pkg.sv
source/sync_ram.sv
source/refill_counter.sv
source/tag_match.sv
source/data_ways.sv
source/dcache_fsm.sv
source/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

// ==== source/data_ways.sv ====
`default_nettype none

// word-wide data arrays, one RAM per way
module data_ways (
	input wire clk,
	input logic lookup_en,
	input logic [dcache_pkg::INDEX_W-1:0] index,
	input logic [dcache_pkg::OFFSET_W-1:0] word_off,
	input dcache_pkg::way_mask_t hit,
	input logic store_we,
	input dcache_pkg::word_t store_data,
	input logic [dcache_pkg::STRB_W-1:0] strobe,
	input logic fill_we,
	input dcache_pkg::way_mask_t victim,
	input logic [dcache_pkg::OFFSET_W-1:0] beat_idx,
	input dcache_pkg::word_t fill_data,
	output dcache_pkg::word_t rdata
);

	import dcache_pkg::*;

	localparam int DEPTH = SETS * LINE_WORDS;

	logic [INDEX_W+OFFSET_W-1:0] ram_addr;
	way_mask_t ram_en;
	way_mask_t ram_we;
	word_t ram_wdata;
	word_t word_rd [WAYS];
	word_t hit_word;
	word_t merged;
	// requested word caught during the refill
	word_t crit_word;
	// last access was a refill, so answer from crit_word
	logic from_fill;

	// refill walks the line by beat, otherwise the request picks the word
	assign ram_addr = {index, fill_we ? beat_idx : word_off};
	assign ram_wdata = fill_we ? fill_data : merged;

	for (genvar i = 0; i < WAYS; i++) begin : g_way
		assign ram_we[i] = (store_we & hit[i]) | (fill_we & victim[i]);
		assign ram_en[i] = lookup_en | ram_we[i];

		sync_ram #(
			.payload_t(word_t),
			.DEPTH(DEPTH)
		) u_data_ram (
			.clk(clk),
			.en(ram_en[i]),
			.we(ram_we[i]),
			.addr(ram_addr),
			.wdata(ram_wdata),
			.rdata(word_rd[i])
		);
	end

	// hit is one-hot or zero, so an or-reduction selects the way
	always_comb begin
		hit_word = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit[w]) begin
				hit_word = hit_word | word_rd[w];
			end
		end
	end

	// store bytes replace the cached ones under strobe
	always_comb begin
		for (int b = 0; b < STRB_W; b++) begin
			merged[b*8 +: 8] = strobe[b] ? store_data[b*8 +: 8] : hit_word[b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_en) begin
			from_fill <= 1'b0;
		end else if (fill_we) begin
			from_fill <= 1'b1;
		end
		if (fill_we && beat_idx == word_off) begin
			crit_word <= fill_data;
		end
	end

	assign rdata = from_fill ? crit_word : hit_word;

endmodule

`default_nettype wire

// ==== source/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
// four ways with round-robin replacement
`define DCACHE_WAYS 4

// sets selected by address bits 9:6
`define DCACHE_SETS 16

// 64-bit words per 64-byte line
`define DCACHE_LINE_WORDS 8

// physical address width
`define DCACHE_ADDR_W 32

// tag is what remains above index and line offset
`define DCACHE_TAG_W 22

`endif

// ==== source/dcache_fsm.sv ====
`default_nettype none

// blocking cache controller
// one request at a time, lookup overlaps the RAM read
module dcache_fsm (
	input wire clk,
	input wire rst,
	input logic valid,
	input dcache_pkg::cpu_req_t req,
	output logic ready,
	input dcache_pkg::way_mask_t hit,
	input logic [dcache_pkg::OFFSET_W-1:0] beat_idx,
	output logic lookup_en,
	output logic store_we,
	output logic fill_we,
	output logic tag_install,
	output dcache_pkg::cpu_req_t cur_req,
	output logic ar_valid,
	input logic ar_ready,
	output dcache_pkg::axi_ar_t ar,
	input logic r_valid,
	input dcache_pkg::axi_r_t r,
	output logic aw_valid,
	input logic aw_ready,
	output dcache_pkg::axi_aw_t aw,
	output logic w_valid,
	input logic w_ready,
	output dcache_pkg::axi_w_t w,
	input logic b_valid
);

	import dcache_pkg::*;

	localparam logic [OFFSET_W-1:0] LAST_BEAT = OFFSET_W'(LINE_WORDS - 1);

	cache_state_t state;
	cache_state_t state_next;
	// request held for the whole operation
	cpu_req_t req_q;
	logic accept;
	logic stalled;

	// the cycle with ready high is skipped, valid is still up then
	assign accept = (state == idle) && valid && !ready;

	// idle passes the new request through so the RAMs can read at once
	assign cur_req = (state == idle) ? req : req_q;

	assign lookup_en = accept;
	// merge only when the store found its line
	assign store_we = (state == lookup) && req_q.write && (hit != '0);
	// R beats are never back-pressured
	assign fill_we = (state == refill) && r_valid;
	assign tag_install = fill_we && (beat_idx == LAST_BEAT);

	assign ar_valid = (state == refill_addr);
	assign aw_valid = (state == write_addr);
	assign w_valid = (state == write_data);

	always_comb begin
		// refill always starts at the first word of the line
		ar.addr = {req_q.addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
		aw.addr = req_q.addr;
		// single-beat write, so every W is the last
		w.data = req_q.data;
		w.strb = req_q.strb;
		w.last = 1'b1;
	end

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (accept) begin
					state_next = lookup;
				end
			end
			lookup: begin
				// write-through, every store goes to memory
				if (req_q.write) begin
					state_next = write_addr;
				end else if (hit != '0) begin
					state_next = respond;
				end else begin
					state_next = refill_addr;
				end
			end
			refill_addr: begin
				if (ar_ready) begin
					state_next = refill;
				end
			end
			refill: begin
				if (r_valid && r.last) begin
					state_next = respond;
				end
			end
			respond: begin
				state_next = idle;
			end
			write_addr: begin
				if (aw_ready) begin
					state_next = write_data;
				end
			end
			write_data: begin
				if (w_ready) begin
					state_next = write_resp;
				end
			end
			write_resp: begin
				if (b_valid) begin
					state_next = idle;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			ready <= 1'b0;
		end else begin
			state <= state_next;
			// one-cycle pulse after respond or the write response
			ready <= (state == respond) || (state == write_resp && b_valid);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
	end

	assign stalled = (ar_valid && !ar_ready) || (aw_valid && !aw_ready) ||
		(w_valid && !w_ready);

	// requester keeps valid up until it sees ready
	a_ready_valid: assert property (
		@(posedge clk) disable iff (rst) ready |-> valid
	);

	// a stalled channel freezes the controller
	a_stall_hold: assert property (
		@(posedge clk) disable iff (rst) stalled |=> $stable(state)
	);

	// r.last from memory lines up with the beat counter
	a_last_beat: assert property (
		@(posedge clk) disable iff (rst) (fill_we && r.last) |-> tag_install
	);

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

	// geometry taken over from the config header
	localparam int WAYS = `DCACHE_WAYS;
	localparam int SETS = `DCACHE_SETS;
	localparam int LINE_WORDS = `DCACHE_LINE_WORDS;
	localparam int ADDR_W = `DCACHE_ADDR_W;
	localparam int TAG_W = `DCACHE_TAG_W;

	// word and strobe sizes of the load/store port
	localparam int WORD_W = 64;
	localparam int STRB_W = WORD_W / 8;

	// address slices: byte offset, word offset, index, tag
	localparam int BYTE_W = $clog2(STRB_W);
	localparam int OFFSET_W = $clog2(LINE_WORDS);
	localparam int INDEX_W = $clog2(SETS);
	localparam int LINE_OFF_W = OFFSET_W + BYTE_W;
	localparam int INDEX_LSB = LINE_OFF_W;
	localparam int TAG_LSB = INDEX_LSB + INDEX_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WAYS-1:0] way_mask_t;

	// one CPU access, held by the requester until ready
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		word_t data;
		logic [STRB_W-1:0] strb;
		logic write;
	} cpu_req_t;

	typedef struct packed {logic [ADDR_W-1:0] addr;} axi_ar_t;
	typedef struct packed {word_t data; logic last;} axi_r_t;
	typedef struct packed {logic [ADDR_W-1:0] addr;} axi_aw_t;
	typedef struct packed {word_t data; logic [STRB_W-1:0] strb; logic last;} axi_w_t;

	typedef enum logic [2:0] {
		idle, lookup, refill_addr, refill, respond, write_addr, write_data, write_resp
	} cache_state_t;

endpackage

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

// data cache top, controller plus arrays
module dcache_top (
	input wire clk,
	input wire rst,
	input logic valid,
	input dcache_pkg::cpu_req_t req,
	output logic ready,
	output dcache_pkg::word_t rdata,
	output logic ar_valid,
	input logic ar_ready,
	output dcache_pkg::axi_ar_t ar,
	input logic r_valid,
	input dcache_pkg::axi_r_t r,
	output logic aw_valid,
	input logic aw_ready,
	output dcache_pkg::axi_aw_t aw,
	output logic w_valid,
	input logic w_ready,
	output dcache_pkg::axi_w_t w,
	input logic b_valid
);

	import dcache_pkg::*;

	cpu_req_t cur_req;
	way_mask_t hit;
	way_mask_t victim;
	logic [OFFSET_W-1:0] beat_idx;
	logic lookup_en;
	logic store_we;
	logic fill_we;
	logic tag_install;

	dcache_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.req(req),
		.ready(ready),
		.hit(hit),
		.beat_idx(beat_idx),
		.lookup_en(lookup_en),
		.store_we(store_we),
		.fill_we(fill_we),
		.tag_install(tag_install),
		.cur_req(cur_req),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar(ar),
		.r_valid(r_valid),
		.r(r),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw(aw),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w(w),
		.b_valid(b_valid)
	);

	refill_counter u_refill_counter (
		.clk(clk),
		.rst(rst),
		.beat(fill_we),
		.done(tag_install),
		.beat_idx(beat_idx),
		.victim(victim)
	);

	tag_match u_tag_match (
		.clk(clk),
		.rst(rst),
		.lookup_en(lookup_en),
		.index(cur_req.addr[TAG_LSB-1:INDEX_LSB]),
		.tag(cur_req.addr[ADDR_W-1:TAG_LSB]),
		.install(tag_install),
		.victim(victim),
		.hit(hit)
	);

	data_ways u_data_ways (
		.clk(clk),
		.lookup_en(lookup_en),
		.index(cur_req.addr[TAG_LSB-1:INDEX_LSB]),
		.word_off(cur_req.addr[LINE_OFF_W-1:BYTE_W]),
		.hit(hit),
		.store_we(store_we),
		.store_data(cur_req.data),
		.strobe(cur_req.strb),
		.fill_we(fill_we),
		.victim(victim),
		.beat_idx(beat_idx),
		.fill_data(r.data),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

// ==== source/refill_counter.sv ====
`default_nettype none

// refill beat index and global round-robin victim
module refill_counter (
	input wire clk,
	input wire rst,
	input logic beat,
	input logic done,
	output logic [dcache_pkg::OFFSET_W-1:0] beat_idx,
	output dcache_pkg::way_mask_t victim
);

	import dcache_pkg::*;

	localparam logic [OFFSET_W-1:0] LAST_BEAT = OFFSET_W'(LINE_WORDS - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_idx <= '0;
			// way 0 is replaced first
			victim <= way_mask_t'(1);
		end else begin
			// one step per accepted R beat, back to 0 after the last
			if (beat) begin
				if (beat_idx == LAST_BEAT) begin
					beat_idx <= '0;
				end else begin
					beat_idx <= beat_idx + 1'b1;
				end
			end
			// pointer is shared by all sets
			// advance once the refilled line is installed
			if (done) begin
				victim <= {victim[WAYS-2:0], victim[WAYS-1]};
			end
		end
	end

	// exactly one way is ever picked for replacement
	a_victim_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot(victim)
	);

endmodule

`default_nettype wire

// ==== source/sync_ram.sv ====
`default_nettype none

// single-port RAM with registered output
// payload type is chosen by the instantiating block
module sync_ram #(
	parameter type payload_t = logic [63:0],
	parameter int DEPTH = 16
) (
	input wire clk,
	input logic en,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] addr,
	input payload_t wdata,
	output payload_t rdata
);

	payload_t mem [DEPTH];

	// output register only moves when enabled
	// so a read result stays put until the next access
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
				// write-through to the output port
				rdata <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/tag_match.sv ====
`default_nettype none

// tag store and hit detection for all ways
module tag_match (
	input wire clk,
	input wire rst,
	input logic lookup_en,
	input logic [dcache_pkg::INDEX_W-1:0] index,
	input dcache_pkg::tag_t tag,
	input logic install,
	input dcache_pkg::way_mask_t victim,
	output dcache_pkg::way_mask_t hit
);

	import dcache_pkg::*;

	// valid bits per way and set
	logic [WAYS-1:0][SETS-1:0] valid_bits;
	// valid bits of the set last looked up
	way_mask_t valid_q;
	// tag RAM controls and read ports
	way_mask_t ram_en;
	way_mask_t ram_we;
	tag_t tag_rd [WAYS];

	for (genvar i = 0; i < WAYS; i++) begin : g_way
		// install only touches the victim way
		assign ram_we[i] = install & victim[i];
		assign ram_en[i] = lookup_en | ram_we[i];

		sync_ram #(
			.payload_t(tag_t),
			.DEPTH(SETS)
		) u_tag_ram (
			.clk(clk),
			.en(ram_en[i]),
			.we(ram_we[i]),
			.addr(index),
			.wdata(tag),
			.rdata(tag_rd[i])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			valid_q <= '0;
		end else begin
			// sample valid bits in the same cycle as the tag RAM read
			if (lookup_en) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[w] <= valid_bits[w][index];
				end
			end
			if (install) begin
				for (int w = 0; w < WAYS; w++) begin
					if (victim[w]) begin
						valid_bits[w][index] <= 1'b1;
					end
				end
			end
		end
	end

	// compare read tags with the tag of the request
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit[w] = valid_q[w] && (tag_rd[w] == tag);
		end
	end

	// a line lives in at most one way of its set
	a_hit_onehot0: assert property (
		@(posedge clk) disable iff (rst) $onehot0(hit)
	);

endmodule

`default_nettype wire

// ==== verif/dcache_mem_model.sv ====
`default_nettype none

// AXI slave memory, sparse, with a log of the requests it saw
module dcache_mem_model (
	input wire clk,
	input wire rst,
	// channel stalls, bit 0 ar, bit 1 aw, bit 2 w
	input logic [2:0] stall,
	input logic ar_valid,
	output logic ar_ready,
	input dcache_pkg::axi_ar_t ar,
	output logic r_valid,
	output dcache_pkg::axi_r_t r,
	input logic aw_valid,
	output logic aw_ready,
	input dcache_pkg::axi_aw_t aw,
	input logic w_valid,
	output logic w_ready,
	input dcache_pkg::axi_w_t w,
	output logic b_valid
);

	import dcache_pkg::*;

	// keyed by word address, absent words hold the fill pattern
	word_t mem [logic [28:0]];
	axi_ar_t ar_log [$];
	int aw_count;
	int w_count;
	axi_aw_t last_aw;
	axi_w_t last_w;
	// refill burst in progress
	logic reading;
	logic [2:0] beat;
	logic [31:0] base;
	word_t merged;

	// fill pattern, every address bit reaches the word
	function automatic word_t fill_word(input logic [31:0] a);
		return {a * 32'h9e37_79b1, a ^ 32'hc3a5_5a3c};
	endfunction

	function automatic word_t read_word(input logic [31:0] a);
		if (mem.exists(a[31:3])) begin
			return mem[a[31:3]];
		end
		return fill_word({a[31:3], 3'b000});
	endfunction

	assign ar_ready = !stall[0];
	assign aw_ready = !stall[1];
	assign w_ready = !stall[2];

	always @(posedge clk) begin
		if (rst) begin
			r_valid <= 1'b0;
			r <= '0;
			b_valid <= 1'b0;
			reading <= 1'b0;
			beat <= '0;
			aw_count <= 0;
			w_count <= 0;
		end else begin
			if (ar_valid && ar_ready) begin
				ar_log.push_back(ar);
				base <= ar.addr;
				reading <= 1'b1;
				beat <= '0;
			end
			// eight back-to-back beats, last one flagged
			r_valid <= reading;
			if (reading) begin
				r.data <= read_word(base + {26'd0, beat, 3'b000});
				r.last <= (beat == 3'd7);
				beat <= beat + 3'd1;
				if (beat == 3'd7) begin
					reading <= 1'b0;
				end
			end
			if (aw_valid && aw_ready) begin
				last_aw <= aw;
				aw_count <= aw_count + 1;
			end
			// response one cycle after the data beat
			b_valid <= w_valid && w_ready;
			if (w_valid && w_ready) begin
				// address always came first, so last_aw belongs to this beat
				merged = read_word(last_aw.addr);
				for (int b = 0; b < 8; b++) begin
					if (w.strb[b]) begin
						merged[b*8 +: 8] = w.data[b*8 +: 8];
					end
				end
				mem[last_aw.addr[31:3]] = merged;
				last_w <= w;
				w_count <= w_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

	import dcache_pkg::*;

	localparam int N_RANDOM = 300;
	// directed operations plus the random mix, sizes the watchdog
	localparam int N_OPS = 16 + N_RANDOM;

	logic clk;
	logic rst;
	logic valid;
	cpu_req_t req;
	logic ready;
	word_t rdata;
	logic ar_valid;
	logic ar_ready;
	axi_ar_t ar;
	logic r_valid;
	axi_r_t r;
	logic aw_valid;
	logic aw_ready;
	axi_aw_t aw;
	logic w_valid;
	logic w_ready;
	axi_w_t w;
	logic b_valid;
	logic [2:0] stall;
	logic stall_en;

	// reference state: shadow memory, tag slots per set, shared victim pointer
	word_t shadow [logic [28:0]];
	tag_t tag_slot [SETS][WAYS];
	logic slot_valid [SETS][WAYS];
	int rr;
	logic [15:0] lfsr;
	logic [15:0] stall_lfsr;
	string test_name;
	// expected results in request order
	word_t exp_data [$];
	logic exp_load [$];

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(8)) u_clk (.clk(clk), .rst(rst));

	dcache_mem_model u_mem (
		.clk(clk), .rst(rst), .stall(stall),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar), .r_valid(r_valid), .r(r),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w), .b_valid(b_valid)
	);

	dcache_top dut (
		.clk(clk), .rst(rst), .valid(valid), .req(req), .ready(ready), .rdata(rdata),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar), .r_valid(r_valid), .r(r),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
		.w_valid(w_valid), .w_ready(w_ready), .w(w), .b_valid(b_valid)
	);

	// memory contents before any store
	function automatic word_t mem_init(input logic [31:0] a);
		return {a * 32'h9e37_79b1, a ^ 32'hc3a5_5a3c};
	endfunction

	// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], state[0]};
			state = lfsr_next(state);
		end
	endtask

	function automatic word_t ref_read(input logic [31:0] a);
		if (shadow.exists(a[31:3])) begin
			return shadow[a[31:3]];
		end
		return mem_init({a[31:3], 3'b000});
	endfunction

	task automatic ref_store(input cpu_req_t rq);
		word_t cur;
		cur = ref_read(rq.addr);
		for (int b = 0; b < STRB_W; b++) begin
			if (rq.strb[b]) begin
				cur[b*8 +: 8] = rq.data[b*8 +: 8];
			end
		end
		shadow[rq.addr[31:3]] = cur;
	endtask

	// loads only, a miss installs into the way the pointer names
	task automatic ref_lookup(input logic [31:0] a, output logic miss);
		logic [INDEX_W-1:0] idx;
		tag_t tag;
		idx = a[TAG_LSB-1:INDEX_LSB];
		tag = a[ADDR_W-1:TAG_LSB];
		miss = 1'b1;
		for (int k = 0; k < WAYS; k++) begin
			if (slot_valid[idx][k] && tag_slot[idx][k] == tag) begin
				miss = 1'b0;
			end
		end
		if (miss) begin
			tag_slot[idx][rr] = tag;
			slot_valid[idx][rr] = 1'b1;
			rr = (rr + 1) % WAYS;
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first wrong word");
		end
	endtask

	task automatic check_way(input string name, input way_mask_t exp, input way_mask_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first wrong refill count");
		end
	endtask

	task automatic check_addr(input string name, input axi_ar_t exp, input axi_ar_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first wrong address");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first wrong count");
		end
	endtask

	// one request through the handshake, then its bus traffic is checked
	task automatic run_op(input cpu_req_t rq, output int edges);
		int ar_before;
		int aw_before;
		int w_before;
		logic miss;
		axi_ar_t exp_ar;
		ar_before = u_mem.ar_log.size();
		aw_before = u_mem.aw_count;
		w_before = u_mem.w_count;
		miss = 1'b0;
		if (rq.write) begin
			ref_store(rq);
			exp_data.push_back('0);
			exp_load.push_back(1'b0);
		end else begin
			ref_lookup(rq.addr, miss);
			exp_data.push_back(ref_read(rq.addr));
			exp_load.push_back(1'b1);
		end
		@(posedge clk);
		valid <= 1'b1;
		req <= rq;
		// counts rising edges from the one that samples valid
		edges = -1;
		do begin
			@(negedge clk);
			edges++;
		end while (!ready);
		@(posedge clk);
		valid <= 1'b0;
		check_way({test_name, " refills"}, way_mask_t'(miss ? 1 : 0),
			way_mask_t'(u_mem.ar_log.size() - ar_before));
		if (miss) begin
			exp_ar.addr = rq.addr & ~32'h3f;
			check_addr({test_name, " ar address"}, exp_ar, u_mem.ar_log[ar_before]);
		end
		check_count({test_name, " aw count"}, rq.write ? 1 : 0, u_mem.aw_count - aw_before);
		check_count({test_name, " w count"}, rq.write ? 1 : 0, u_mem.w_count - w_before);
		if (rq.write) begin
			exp_ar.addr = rq.addr;
			check_addr({test_name, " aw address"}, exp_ar, axi_ar_t'(u_mem.last_aw));
			check_word({test_name, " w data"}, rq.data, u_mem.last_w.data);
			check_word({test_name, " w strobe"}, word_t'(rq.strb), word_t'(u_mem.last_w.strb));
			// single-beat write, so the one W beat is flagged last
			check_count({test_name, " w last"}, 1, int'(u_mem.last_w.last));
		end
	endtask

	// compare process, each ready pulse against the oldest expected result
	always @(negedge clk) begin
		if (!rst && ready) begin
			if (exp_data.size() == 0) begin
				$display("ready pulse arrived with no request outstanding");
				$display("*** TEST FAILED ***");
				$fatal(1, "unexpected ready");
			end else begin
				if (exp_load[0]) begin
					check_word({test_name, " load data"}, exp_data[0], rdata);
				end
				exp_data.delete(0);
				exp_load.delete(0);
			end
		end
	end

	// random stalls on the address and write data channels
	initial begin
		logic [63:0] sbits;
		stall = '0;
		stall_lfsr = 16'd85;
		forever begin
			@(posedge clk);
			if (stall_en) begin
				take_bits(stall_lfsr, 3, sbits);
				stall <= sbits[2:0];
			end else begin
				stall <= '0;
			end
		end
	end

	initial begin
		repeat (200 * N_OPS) @(posedge clk);
		$display("timeout: the cache did not finish all operations in time");
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		cpu_req_t rq;
		logic [63:0] bits;
		logic [31:0] a;
		int edges;
		valid = 1'b0;
		req = '0;
		stall_en = 1'b0;
		lfsr = 16'd85;
		rr = 0;
		for (int s = 0; s < SETS; s++) begin
			for (int k = 0; k < WAYS; k++) begin
				slot_valid[s][k] = 1'b0;
				tag_slot[s][k] = '0;
			end
		end
		wait (rst == 1'b0);

		test_name = "cold load miss";
		rq = '0;
		rq.addr = 32'h0000_1238;
		run_op(rq, edges);

		// same line, hit path has a fixed latency
		test_name = "repeat load hit";
		rq.addr = 32'h0000_1230;
		run_op(rq, edges);
		check_count("repeat load hit latency", 3, edges);

		test_name = "store hit";
		rq.addr = 32'h0000_1220;
		rq.data = 64'hdead_beef_cafe_f00d;
		rq.strb = 8'b0011_1100;
		rq.write = 1'b1;
		run_op(rq, edges);
		rq = '0;
		rq.addr = 32'h0000_1220;
		run_op(rq, edges);

		// no write-allocate, so the load after it refills
		test_name = "store miss";
		rq.addr = 32'h0002_5008;
		rq.data = 64'h0123_4567_89ab_cdef;
		rq.strb = 8'hf0;
		rq.write = 1'b1;
		run_op(rq, edges);
		rq = '0;
		rq.addr = 32'h0002_5008;
		run_op(rq, edges);

		// five lines of set 5, one more than the ways
		test_name = "replacement";
		for (int pass = 0; pass < 2; pass++) begin
			for (int k = 0; k < 5; k++) begin
				rq = '0;
				rq.addr = 32'h0003_0158 + 32'(k) * 32'h400;
				run_op(rq, edges);
			end
		end

		// small footprint of 8 tags over 4 sets keeps hits and evictions frequent
		test_name = "random mix";
		stall_en = 1'b1;
		for (int i = 0; i < N_RANDOM; i++) begin
			rq = '0;
			take_bits(lfsr, 1, bits);
			rq.write = bits[0];
			take_bits(lfsr, 3, bits);
			a = 32'h0004_0000 | {19'd0, bits[2:0], 10'd0};
			take_bits(lfsr, 2, bits);
			a = a | {24'd0, bits[1:0], 6'd0};
			take_bits(lfsr, 3, bits);
			a = a | {26'd0, bits[2:0], 3'd0};
			rq.addr = a;
			if (rq.write) begin
				take_bits(lfsr, 8, bits);
				rq.strb = bits[7:0];
				take_bits(lfsr, 64, bits);
				rq.data = bits;
			end
			run_op(rq, edges);
		end
		stall_en = 1'b0;

		check_count("results left unchecked", 0, exp_data.size());
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

// free-running clock and a reset held for the first cycles
module tb_clock_gen #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a rising edge so the first cycle out of reset is whole
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire
